//--- hdl/radio_defs.svh
/*
 * Radio core setting addresses and readback selectors
 */

`ifndef RADIO_DEFS_SVH
`define RADIO_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Settings bus addresses

`define SR_TEST        8'd21
`define SR_CODEC_IDLE  8'd22
`define SR_READBACK    8'd32

// Bit 0 run enable, bit 1 clears the sticky underflow flag
`define SR_TX_CTRL     8'd64

// A sample count written here starts an RX burst
`define SR_RX_CTRL     8'd96
`define SR_RX_SID      8'd97

// High word is held until the low word commits the full time
`define SR_TIME_HI     8'd128
`define SR_TIME_LO     8'd129

////////////////////////////////////////////////////////////////////////////
// Readback selectors

`define RB_TEST        3'd0
`define RB_TIME        3'd1
`define RB_LASTPPS     3'd2
`define RB_CODEC       3'd3
`define RB_STATUS      3'd4

`endif

//--- hdl/radio_pkg.sv
/*
 * Radio core shared types
 * Stream beats, the settings bus and the two views of a control word
 */

package radio_pkg;

   // One beat of a 64-bit packet stream
   typedef struct packed {
      logic        last;
      logic [63:0] data;
   } stream_beat_t;

   // Settings bus, one write per strobe
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // Packet header view
   typedef struct packed {
      logic [11:0] seqnum;
      logic [19:0] length;
      logic [31:0] sid;
   } ctrl_hdr_t;

   // Settings command view
   typedef struct packed {
      logic [7:0]  addr;
      logic [23:0] pad;
      logic [31:0] data;
   } ctrl_cmd_t;

   typedef union packed {
      ctrl_hdr_t hdr;
      ctrl_cmd_t cmd;
   } ctrl_word_u;

endpackage

//--- hdl/radio_ctrl_proc.sv
/*
 * Control packet processor
 * Takes a header and a command beat, strobes the settings bus and
 * answers with the echoed header and the readback word
 */

`timescale 1ns/1ns

module radio_ctrl_proc (
   input  logic                    radio_clk,
   input  logic                    i_reset,
   input  radio_pkg::stream_beat_t i_ctrl,
   input  logic                    i_ctrl_valid,
   output logic                    o_ctrl_ready,
   output radio_pkg::stream_beat_t o_resp,
   output logic                    o_resp_valid,
   input  logic                    i_resp_ready,
   output radio_pkg::set_bus_t     o_set,
   input  logic [63:0]             i_readback
);

   localparam logic [2:0] ST_HDR   = 3'd0;
   localparam logic [2:0] ST_CMD   = 3'd1;
   localparam logic [2:0] ST_SET   = 3'd2;
   localparam logic [2:0] ST_RESP0 = 3'd3;
   localparam logic [2:0] ST_RESP1 = 3'd4;

   logic [2:0]            state;
   logic                  ctrl_xfer;
   logic                  resp_xfer;
   radio_pkg::ctrl_word_u ctrl_w;
   radio_pkg::ctrl_word_u echo_w;
   logic [11:0]           seqnum_q;
   logic [31:0]           sid_q;
   logic                  set_stb;
   logic [7:0]            set_addr;
   logic [31:0]           set_data;
   logic                  resp_last;
   logic [63:0]           resp_data;

   assign ctrl_w       = i_ctrl.data;
   assign o_ctrl_ready = (state == ST_HDR) || (state == ST_CMD);
   assign ctrl_xfer    = i_ctrl_valid && o_ctrl_ready;
   assign resp_xfer    = o_resp_valid && i_resp_ready;
   assign o_set        = '{stb: set_stb, addr: set_addr, data: set_data};
   assign o_resp       = '{last: resp_last, data: resp_data};

   // Echoed header always reports a single response payload beat
   always_comb begin
      echo_w.hdr.seqnum = seqnum_q;
      echo_w.hdr.length = 20'd1;
      echo_w.hdr.sid    = sid_q;
   end

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         state        <= ST_HDR;
         set_stb      <= 1'b0;
         o_resp_valid <= 1'b0;
      end else begin
         set_stb <= 1'b0;
         case (state)
            ST_HDR: if (ctrl_xfer) state <= ST_CMD;
            ST_CMD: begin
               if (ctrl_xfer) begin
                  state   <= ST_SET;
                  set_stb <= 1'b1;
               end
            end
            ST_SET: begin
               state        <= ST_RESP0;
               o_resp_valid <= 1'b1;
            end
            ST_RESP0: if (resp_xfer) state <= ST_RESP1;
            ST_RESP1: begin
               if (resp_xfer) begin
                  state        <= ST_HDR;
                  o_resp_valid <= 1'b0;
               end
            end
            default: state <= ST_HDR;
         endcase
      end
   end

   // Captured fields and response words
   always_ff @(posedge radio_clk) begin
      if (state == ST_HDR && ctrl_xfer) begin
         seqnum_q <= ctrl_w.hdr.seqnum;
         sid_q    <= ctrl_w.hdr.sid;
      end
      if (state == ST_CMD && ctrl_xfer) begin
         set_addr <= ctrl_w.cmd.addr;
         set_data <= ctrl_w.cmd.data;
      end
      if (state == ST_SET) begin
         resp_last <= 1'b0;
         resp_data <= echo_w;
      end
      // Readback taken as the second beat goes valid, after the write landed
      if (state == ST_RESP0 && resp_xfer) begin
         resp_last <= 1'b1;
         resp_data <= i_readback;
      end
   end

endmodule

//--- hdl/timekeeper.sv
/*
 * Timekeeper
 * Free-running 64-bit radio time with a settable value and a PPS latch
 */

`timescale 1ns/1ns

`include "radio_defs.svh"

module timekeeper (
   input  logic                radio_clk,
   input  logic                i_reset,
   input  radio_pkg::set_bus_t i_set,
   input  logic                i_pps,
   output logic [63:0]         o_vita_time,
   output logic [63:0]         o_time_lastpps
);

   logic [31:0] time_hi;
   logic        pps_q;
   logic        pps_edge;
   logic        load_lo;

   assign pps_edge = i_pps && !pps_q;
   assign load_lo  = i_set.stb && (i_set.addr == `SR_TIME_LO);

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_vita_time    <= 64'd0;
         o_time_lastpps <= 64'd0;
         time_hi        <= 32'd0;
         pps_q          <= 1'b0;
      end else begin
         pps_q <= i_pps;

         // Pending high word, committed with the low word
         if (i_set.stb && i_set.addr == `SR_TIME_HI)
            time_hi <= i_set.data;

         if (load_lo)
            o_vita_time <= {time_hi, i_set.data};
         else
            o_vita_time <= o_vita_time + 64'd1;

         if (pps_edge)
            o_time_lastpps <= o_vita_time;
      end
   end

endmodule

//--- hdl/radio_settings.sv
/*
 * Radio settings registers
 * Test, codec idle and readback select registers with the readback mux
 */

`timescale 1ns/1ns

`include "radio_defs.svh"

module radio_settings (
   input  logic                radio_clk,
   input  logic                i_reset,
   input  radio_pkg::set_bus_t i_set,
   input  logic [63:0]         i_vita_time,
   input  logic [63:0]         i_time_lastpps,
   input  logic [31:0]         i_tx_word,
   input  logic [31:0]         i_rx_word,
   input  logic                i_tx_underflow,
   input  logic                i_rx_overflow,
   input  logic [11:0]         i_rx_seqnum,
   output logic [31:0]         o_tx_idle,
   output logic [63:0]         o_readback
);

   logic [31:0] test_reg;
   logic [2:0]  rb_sel;

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         test_reg  <= 32'd0;
         o_tx_idle <= 32'd0;
         rb_sel    <= `RB_TEST;
      end else if (i_set.stb) begin
         case (i_set.addr)
            `SR_TEST:       test_reg  <= i_set.data;
            `SR_CODEC_IDLE: o_tx_idle <= i_set.data;
            `SR_READBACK:   rb_sel    <= i_set.data[2:0];
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Readback mux
   // Status word has rx overflow in bit 13, tx underflow in bit 12 and rx seqnum below

   always_comb begin
      case (rb_sel)
         `RB_TEST:    o_readback = {32'd0, test_reg};
         `RB_TIME:    o_readback = i_vita_time;
         `RB_LASTPPS: o_readback = i_time_lastpps;
         `RB_CODEC:   o_readback = {i_tx_word, i_rx_word};
         `RB_STATUS:  o_readback = {50'd0, i_rx_overflow, i_tx_underflow, i_rx_seqnum};
         default:     o_readback = 64'd0;
      endcase
   end

endmodule

//--- hdl/tx_sample_path.sv
/*
 * TX sample path
 * Splits 64-bit beats into two DAC words while running, else the idle word
 */

`timescale 1ns/1ns

`include "radio_defs.svh"

module tx_sample_path (
   input  logic                    radio_clk,
   input  logic                    i_reset,
   input  radio_pkg::set_bus_t     i_set,
   input  radio_pkg::stream_beat_t i_tx,
   input  logic                    i_tx_valid,
   output logic                    o_tx_ready,
   input  logic [31:0]             i_tx_idle,
   output logic [31:0]             o_tx,
   output logic                    o_underflow
);

   logic        run;
   logic        held;
   logic        phase;
   logic [63:0] beat_q;
   logic        active;

   // Phase 0 shows the upper word, phase 1 the lower word
   assign active     = run && held;
   assign o_tx_ready = !held || (active && phase);
   assign o_tx       = active ? (phase ? beat_q[31:0] : beat_q[63:32]) : i_tx_idle;

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         run         <= 1'b0;
         held        <= 1'b0;
         phase       <= 1'b0;
         o_underflow <= 1'b0;
      end else begin
         if (i_tx_valid && o_tx_ready) begin
            held  <= 1'b1;
            phase <= 1'b0;
         end else if (active) begin
            phase <= !phase;
            if (phase) held <= 1'b0;
         end

         if (i_set.stb && i_set.addr == `SR_TX_CTRL) begin
            run <= i_set.data[0];
            if (i_set.data[1]) o_underflow <= 1'b0;
         end else if (run && !held) begin
            o_underflow <= 1'b1;
         end
      end
   end

   // Only the data is kept since packet boundaries mean nothing to the DAC
   always_ff @(posedge radio_clk) begin
      if (i_tx_valid && o_tx_ready) beat_q <= i_tx.data;
   end

endmodule

//--- hdl/rx_framer.sv
/*
 * RX framer
 * Captures a programmed burst of ADC words and sends it as a header beat
 * followed by data beats holding two words each
 */

`timescale 1ns/1ns

`include "radio_defs.svh"

module rx_framer (
   input  logic                    radio_clk,
   input  logic                    i_reset,
   input  radio_pkg::set_bus_t     i_set,
   input  logic [31:0]             i_rx,
   output radio_pkg::stream_beat_t o_rx,
   output logic                    o_rx_valid,
   input  logic                    i_rx_ready,
   output logic                    o_overflow,
   output logic [11:0]             o_seqnum
);

   logic                  start;
   logic [19:0]           start_pairs;
   logic                  running;
   logic                  half;
   logic [19:0]           pairs_left;
   logic [31:0]           sid_q;
   logic [31:0]           word_hi;
   logic                  slot_free;
   logic                  pair_done;
   logic                  beat_last;
   logic [63:0]           beat_data;
   radio_pkg::ctrl_word_u hdr_w;

   assign start       = i_set.stb && (i_set.addr == `SR_RX_CTRL);
   assign start_pairs = i_set.data[20:1];
   assign slot_free   = !o_rx_valid || i_rx_ready;
   assign pair_done   = running && half;
   assign o_rx        = '{last: beat_last, data: beat_data};

   always_comb begin
      hdr_w.hdr.seqnum = o_seqnum;
      hdr_w.hdr.length = start_pairs;
      hdr_w.hdr.sid    = sid_q;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Burst control

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         running    <= 1'b0;
         half       <= 1'b0;
         pairs_left <= 20'd0;
         sid_q      <= 32'd0;
         o_rx_valid <= 1'b0;
         o_overflow <= 1'b0;
         o_seqnum   <= 12'd0;
      end else begin
         if (i_set.stb && i_set.addr == `SR_RX_SID) sid_q <= i_set.data;
         if (o_rx_valid && i_rx_ready) o_rx_valid <= 1'b0;

         if (start) begin
            running    <= |start_pairs;
            half       <= 1'b0;
            pairs_left <= start_pairs;
            o_overflow <= 1'b0;
            o_rx_valid <= 1'b1;
            // Empty burst is a header only
            if (~|start_pairs) o_seqnum <= o_seqnum + 12'd1;
         end else if (running) begin
            half <= !half;
            if (half) begin
               pairs_left <= pairs_left - 20'd1;
               if (!slot_free) begin
                  // Truncate the burst at the beat that is still waiting
                  o_overflow <= 1'b1;
                  running    <= 1'b0;
                  o_seqnum   <= o_seqnum + 12'd1;
               end else begin
                  o_rx_valid <= 1'b1;
                  if (pairs_left == 20'd1) begin
                     running  <= 1'b0;
                     o_seqnum <= o_seqnum + 12'd1;
                  end
               end
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Pair and output beat registers

   always_ff @(posedge radio_clk) begin
      if (running && !half) word_hi <= i_rx;

      if (start) begin
         beat_last <= ~|start_pairs;
         beat_data <= hdr_w;
      end else if (pair_done) begin
         if (slot_free) begin
            beat_last <= (pairs_left == 20'd1);
            beat_data <= {word_hi, i_rx};
         end else begin
            beat_last <= 1'b1;
         end
      end
   end

endmodule

//--- hdl/radio_core.sv
/*
 * Radio core top level
 * Control processor, timekeeper, settings, TX path and RX framer on one clock
 */

`timescale 1ns/1ns

module radio_core (
   input  logic                    radio_clk,
   input  logic                    i_reset,
   input  logic [31:0]             i_rx,
   output logic [31:0]             o_tx,
   input  logic                    i_pps,
   input  radio_pkg::stream_beat_t i_ctrl,
   input  logic                    i_ctrl_valid,
   output logic                    o_ctrl_ready,
   output radio_pkg::stream_beat_t o_resp,
   output logic                    o_resp_valid,
   input  logic                    i_resp_ready,
   input  radio_pkg::stream_beat_t i_tx,
   input  logic                    i_tx_valid,
   output logic                    o_tx_ready,
   output radio_pkg::stream_beat_t o_rx,
   output logic                    o_rx_valid,
   input  logic                    i_rx_ready
);

   radio_pkg::set_bus_t set_bus;
   logic [63:0]         readback;
   logic [63:0]         vita_time;
   logic [63:0]         time_lastpps;
   logic [31:0]         tx_idle;
   logic                tx_underflow;
   logic                rx_overflow;
   logic [11:0]         rx_seqnum;

   radio_ctrl_proc u_ctrl_proc (
      .radio_clk(radio_clk), .i_reset(i_reset),
      .i_ctrl(i_ctrl), .i_ctrl_valid(i_ctrl_valid), .o_ctrl_ready(o_ctrl_ready),
      .o_resp(o_resp), .o_resp_valid(o_resp_valid), .i_resp_ready(i_resp_ready),
      .o_set(set_bus), .i_readback(readback));

   timekeeper u_timekeeper (
      .radio_clk(radio_clk), .i_reset(i_reset), .i_set(set_bus), .i_pps(i_pps),
      .o_vita_time(vita_time), .o_time_lastpps(time_lastpps));

   // Codec readback sees the live DAC and ADC words
   radio_settings u_settings (
      .radio_clk(radio_clk), .i_reset(i_reset), .i_set(set_bus),
      .i_vita_time(vita_time), .i_time_lastpps(time_lastpps),
      .i_tx_word(o_tx), .i_rx_word(i_rx),
      .i_tx_underflow(tx_underflow), .i_rx_overflow(rx_overflow),
      .i_rx_seqnum(rx_seqnum), .o_tx_idle(tx_idle), .o_readback(readback));

   tx_sample_path u_tx_path (
      .radio_clk(radio_clk), .i_reset(i_reset), .i_set(set_bus),
      .i_tx(i_tx), .i_tx_valid(i_tx_valid), .o_tx_ready(o_tx_ready),
      .i_tx_idle(tx_idle), .o_tx(o_tx), .o_underflow(tx_underflow));

   rx_framer u_rx_framer (
      .radio_clk(radio_clk), .i_reset(i_reset), .i_set(set_bus), .i_rx(i_rx),
      .o_rx(o_rx), .o_rx_valid(o_rx_valid), .i_rx_ready(i_rx_ready),
      .o_overflow(rx_overflow), .o_seqnum(rx_seqnum));

endmodule

//--- verif/radio_checker.sv
/*
 * Radio core protocol checker
 * Stream handshakes, reset behavior, ctrl/resp exclusion and the TX idle word
 */

`timescale 1ns/1ns

`include "radio_defs.svh"

module radio_checker (
   input logic                    radio_clk,
   input logic                    i_reset,
   input logic [31:0]             o_tx,
   input radio_pkg::stream_beat_t i_ctrl,
   input logic                    i_ctrl_valid,
   input logic                    o_ctrl_ready,
   input radio_pkg::stream_beat_t o_resp,
   input logic                    o_resp_valid,
   input logic                    i_resp_ready,
   input radio_pkg::stream_beat_t i_tx,
   input logic                    i_tx_valid,
   input logic                    o_tx_ready,
   input radio_pkg::stream_beat_t o_rx,
   input logic                    o_rx_valid,
   input logic                    i_rx_ready,
   input radio_pkg::set_bus_t     i_set,
   input logic [31:0]             i_tx_idle
);

   int   fail_count = 0;
   logic run_q;

   // TX run state as seen on the settings bus
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         run_q <= 1'b0;
      end else if (i_set.stb && i_set.addr == `SR_TX_CTRL) begin
         run_q <= i_set.data[0];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stream handshakes

   ctrl_hold: assert property (@(posedge radio_clk) disable iff (i_reset)
      i_ctrl_valid && !o_ctrl_ready |=> i_ctrl_valid && $stable(i_ctrl))
   else begin
      fail_count = fail_count + 1;
      $error("ctrl beat dropped or changed before ready");
   end

   resp_hold: assert property (@(posedge radio_clk) disable iff (i_reset)
      o_resp_valid && !i_resp_ready |=> o_resp_valid && $stable(o_resp))
   else begin
      fail_count = fail_count + 1;
      $error("resp beat dropped or changed before ready");
   end

   tx_hold: assert property (@(posedge radio_clk) disable iff (i_reset)
      i_tx_valid && !o_tx_ready |=> i_tx_valid && $stable(i_tx))
   else begin
      fail_count = fail_count + 1;
      $error("tx beat dropped or changed before ready");
   end

   // A truncated burst may raise last on the waiting beat
   rx_hold: assert property (@(posedge radio_clk) disable iff (i_reset)
      o_rx_valid && !i_rx_ready |=>
         o_rx_valid && $stable(o_rx.data) && (o_rx.last || !$past(o_rx.last)))
   else begin
      fail_count = fail_count + 1;
      $error("rx beat dropped or changed before ready");
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reset, exclusion and idle word

   reset_outputs: assert property (@(posedge radio_clk)
      i_reset |=> !o_resp_valid && !o_rx_valid)
   else begin
      fail_count = fail_count + 1;
      $error("output valid high during reset");
   end

   reset_inputs: assert property (@(posedge radio_clk)
      i_reset |-> !i_ctrl_valid && !i_tx_valid)
   else begin
      fail_count = fail_count + 1;
      $error("input valid high during reset");
   end

   ctrl_stalled: assert property (@(posedge radio_clk) disable iff (i_reset)
      o_resp_valid |-> !o_ctrl_ready)
   else begin
      fail_count = fail_count + 1;
      $error("ctrl ready high while a response is pending");
   end

   tx_idle: assert property (@(posedge radio_clk) disable iff (i_reset)
      !run_q |-> o_tx == i_tx_idle)
   else begin
      fail_count = fail_count + 1;
      $error("DAC word differs from the idle word while TX is stopped");
   end

endmodule

bind radio_core radio_checker u_checker (
   .radio_clk(radio_clk), .i_reset(i_reset), .o_tx(o_tx),
   .i_ctrl(i_ctrl), .i_ctrl_valid(i_ctrl_valid), .o_ctrl_ready(o_ctrl_ready),
   .o_resp(o_resp), .o_resp_valid(o_resp_valid), .i_resp_ready(i_resp_ready),
   .i_tx(i_tx), .i_tx_valid(i_tx_valid), .o_tx_ready(o_tx_ready),
   .o_rx(o_rx), .o_rx_valid(o_rx_valid), .i_rx_ready(i_rx_ready),
   .i_set(set_bus), .i_tx_idle(tx_idle));

//--- verif/radio_core_tb.sv
/*
 * Radio core testbench
 * Drives the control, TX and RX streams and checks readback, time and framing
 */

`timescale 1ns/1ns

`include "radio_defs.svh"

module radio_core_tb;

   localparam int TIMEOUT = 200;

   logic                    radio_clk;
   logic                    i_reset;
   logic [31:0]             i_rx;
   logic [31:0]             o_tx;
   logic                    i_pps;
   radio_pkg::stream_beat_t i_ctrl;
   logic                    i_ctrl_valid;
   logic                    o_ctrl_ready;
   radio_pkg::stream_beat_t o_resp;
   logic                    o_resp_valid;
   logic                    i_resp_ready;
   radio_pkg::stream_beat_t i_tx;
   logic                    i_tx_valid;
   logic                    o_tx_ready;
   radio_pkg::stream_beat_t o_rx;
   logic                    o_rx_valid;
   logic                    i_rx_ready;

   int                      errors;
   int                      checks;
   logic [11:0]             ctrl_seq;
   logic [31:0]             ctrl_sid;
   logic [31:0]             rx_sid;
   logic [31:0]             idle_word;
   logic                    capture_tx;
   logic [63:0]             resp_hdr;
   logic [63:0]             resp_rb;
   logic [63:0]             tx_beats[$];
   logic [31:0]             tx_seen[$];
   radio_pkg::stream_beat_t rx_beats[$];

   radio_core u_dut (.*);

   initial begin
      radio_clk = 1'b0;
      forever #20 radio_clk = ~radio_clk;
   end

   // ADC ramp that steps once per cycle
   always @(posedge radio_clk) begin
      #5;
      i_rx = i_rx + 32'd1;
   end

   // Non-idle DAC words sampled mid-cycle
   always @(negedge radio_clk) begin
      if (capture_tx && o_tx != idle_word) tx_seen.push_back(o_tx);
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers

   task automatic next_cycle();
      @(posedge radio_clk);
      #5;
   endtask

   task automatic give_up(input string what);
      $display("timeout while waiting for %s", what);
      $display("FAIL: see errors above");
      $finish;
   endtask

   task automatic check_value(input bit ok, input string name,
                              input logic [63:0] exp, input logic [63:0] act);
      checks++;
      assert (ok) else begin
         errors++;
         $display("error: %s expected 0x%0h actual 0x%0h", name, exp, act);
      end
   endtask

   function automatic logic [31:0] pick_sample();
      logic [31:0] s;
      s = $urandom;
      while (s == idle_word) s = $urandom;
      return s;
   endfunction

   task automatic wait_ctrl_ready();
      int n;
      n = 0;
      while (!o_ctrl_ready) begin
         next_cycle();
         n++;
         if (n > TIMEOUT) give_up("ctrl ready");
      end
   endtask

   // Response beats with random back-pressure
   task automatic take_resp(output logic [63:0] data, output logic last);
      int n;
      n = 0;
      i_resp_ready = ($urandom % 32'd3) != 32'd0;
      while (!(o_resp_valid && i_resp_ready)) begin
         next_cycle();
         i_resp_ready = ($urandom % 32'd3) != 32'd0;
         n++;
         if (n > TIMEOUT) give_up("response beat");
      end
      data = o_resp.data;
      last = o_resp.last;
      next_cycle();
   endtask

   task automatic send_ctrl(input logic [7:0] addr, input logic [31:0] data);
      radio_pkg::ctrl_word_u w;
      radio_pkg::ctrl_word_u exp_hdr;
      logic                  last0;
      logic                  last1;
      ctrl_seq     = ctrl_seq + 12'd1;
      w.hdr.seqnum = ctrl_seq;
      w.hdr.length = 20'd1;
      w.hdr.sid    = ctrl_sid;
      i_ctrl       = '{last: 1'b0, data: w};
      i_ctrl_valid = 1'b1;
      wait_ctrl_ready();
      next_cycle();
      w.cmd.addr   = addr;
      w.cmd.pad    = 24'd0;
      w.cmd.data   = data;
      i_ctrl       = '{last: 1'b1, data: w};
      wait_ctrl_ready();
      next_cycle();
      i_ctrl_valid = 1'b0;
      take_resp(resp_hdr, last0);
      take_resp(resp_rb, last1);
      exp_hdr.hdr.seqnum = ctrl_seq;
      exp_hdr.hdr.length = 20'd1;
      exp_hdr.hdr.sid    = ctrl_sid;
      check_value(resp_hdr == exp_hdr, "resp_header", exp_hdr, resp_hdr);
      check_value(!last0 && last1, "resp_last", 64'd1, 64'({last0, last1}));
   endtask

   task automatic drive_tx(input int count);
      int n;
      for (int b = 0; b < count; b++) begin
         i_tx       = '{last: (b == count - 1), data: tx_beats[b]};
         i_tx_valid = 1'b1;
         n = 0;
         while (!o_tx_ready) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) give_up("tx ready");
         end
         next_cycle();
      end
      i_tx_valid = 1'b0;
   endtask

   // Drops rx ready for 6 cycles once stall_at beats have arrived
   task automatic collect_rx(input int stall_at);
      int n;
      int stall;
      bit done;
      n     = 0;
      stall = 0;
      done  = 1'b0;
      rx_beats.delete();
      i_rx_ready = 1'b1;
      while (!done) begin
         if (o_rx_valid && i_rx_ready) begin
            rx_beats.push_back(o_rx);
            done = o_rx.last;
         end
         next_cycle();
         if (rx_beats.size() == stall_at && stall < 6) begin
            i_rx_ready = 1'b0;
            stall++;
         end else begin
            i_rx_ready = 1'b1;
         end
         n++;
         if (n > TIMEOUT) give_up("rx burst");
      end
   endtask

   task automatic check_burst(input string name, input int pairs,
                              input logic [11:0] seqnum, input bit truncated);
      radio_pkg::ctrl_word_u exp_hdr;
      logic [63:0]           got;
      logic [31:0]           hi;
      logic [31:0]           lo;
      logic [31:0]           prev_lo;
      int                    nbeats;
      exp_hdr.hdr.seqnum = seqnum;
      exp_hdr.hdr.length = pairs[19:0];
      exp_hdr.hdr.sid    = rx_sid;
      nbeats  = rx_beats.size();
      got     = rx_beats[0].data;
      prev_lo = 32'd0;
      check_value(got == exp_hdr, {name, "_header"}, exp_hdr, got);
      check_value(truncated ? (nbeats < pairs + 1) : (nbeats == pairs + 1),
                  {name, "_beats"}, 64'(pairs + 1), 64'(nbeats));
      for (int k = 0; k < nbeats; k++) begin
         hi = rx_beats[k].data[63:32];
         lo = rx_beats[k].data[31:0];
         check_value(rx_beats[k].last == (k == nbeats - 1), {name, "_last"},
                     64'(k == nbeats - 1), 64'(rx_beats[k].last));
         if (k > 0) check_value(lo == hi + 32'd1, {name, "_pair"}, 64'(hi + 32'd1), 64'(lo));
         if (k > 1) check_value(hi == prev_lo + 32'd1, {name, "_consecutive"},
                                64'(prev_lo + 32'd1), 64'(hi));
         prev_lo = lo;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      logic [63:0] t_load;
      logic [63:0] t_a;
      logic [63:0] t_b;
      logic [31:0] value;
      logic [31:0] exp_word;
      int          pairs;
      void'($urandom(45436));
      i_reset      = 1'b1;
      i_rx         = 32'd0;
      i_pps        = 1'b0;
      i_ctrl       = '0;
      i_ctrl_valid = 1'b0;
      i_resp_ready = 1'b1;
      i_tx         = '0;
      i_tx_valid   = 1'b0;
      i_rx_ready   = 1'b1;
      errors       = 0;
      checks       = 0;
      ctrl_seq     = 12'd0;
      ctrl_sid     = $urandom;
      rx_sid       = $urandom;
      idle_word    = 32'd0;
      capture_tx   = 1'b0;
      repeat (4) @(posedge radio_clk);
      #5;
      i_reset = 1'b0;

      // Register readback
      value = $urandom;
      send_ctrl(`SR_TEST, value);
      send_ctrl(`SR_READBACK, {29'd0, `RB_TEST});
      check_value(resp_rb == {32'd0, value}, "test_register", {32'd0, value}, resp_rb);

      // Time load and a PPS edge between two reads
      t_load = {$urandom, $urandom} | 64'h8000_0000_0000_0000;
      send_ctrl(`SR_READBACK, {29'd0, `RB_TIME});
      send_ctrl(`SR_TIME_HI, t_load[63:32]);
      send_ctrl(`SR_TIME_LO, t_load[31:0]);
      t_a = resp_rb;
      check_value(t_a >= t_load && t_a < t_load + 64'd64, "time_after_load", t_load, t_a);
      send_ctrl(`SR_READBACK, {29'd0, `RB_TIME});
      t_b = resp_rb;
      check_value(t_b > t_a, "time_advances", t_a, t_b);
      t_a = t_b;
      i_pps = 1'b1;
      repeat (2) next_cycle();
      i_pps = 1'b0;
      send_ctrl(`SR_READBACK, {29'd0, `RB_TIME});
      t_b = resp_rb;
      send_ctrl(`SR_READBACK, {29'd0, `RB_LASTPPS});
      check_value(resp_rb > t_a && resp_rb < t_b, "pps_latch", t_a, resp_rb);

      // TX idle word, then six beats with run on
      idle_word = $urandom;
      send_ctrl(`SR_CODEC_IDLE, idle_word);
      check_value(o_tx == idle_word, "tx_idle", 64'(idle_word), 64'(o_tx));

      // Codec readback shows the idle DAC word and a recent ADC word
      send_ctrl(`SR_READBACK, {29'd0, `RB_CODEC});
      check_value(resp_rb[63:32] == idle_word, "codec_tx_word", 64'(idle_word),
                  64'(resp_rb[63:32]));
      check_value((i_rx - resp_rb[31:0]) < 32'd64, "codec_rx_word", 64'(i_rx),
                  64'(resp_rb[31:0]));

      tx_beats.delete();
      for (int b = 0; b < 6; b++) tx_beats.push_back({pick_sample(), pick_sample()});
      capture_tx = 1'b1;
      fork
         drive_tx(6);
         send_ctrl(`SR_TX_CTRL, 32'd3);
      join
      repeat (4) next_cycle();
      send_ctrl(`SR_READBACK, {29'd0, `RB_STATUS});
      check_value(resp_rb[12], "tx_underflow", 64'd1, 64'(resp_rb[12]));
      send_ctrl(`SR_TX_CTRL, 32'd0);
      capture_tx = 1'b0;
      check_value(tx_seen.size() == 12, "tx_word_count", 64'd12, 64'(tx_seen.size()));
      for (int k = 0; k < 12 && k < tx_seen.size(); k++) begin
         exp_word = (k % 2 == 0) ? tx_beats[k / 2][63:32] : tx_beats[k / 2][31:0];
         check_value(tx_seen[k] == exp_word, "tx_word", 64'(exp_word), 64'(tx_seen[k]));
      end

      // RX bursts with ready held high
      send_ctrl(`SR_RX_SID, rx_sid);
      pairs = 4 + int'($urandom % 32'd5);
      fork
         collect_rx(-1);
         send_ctrl(`SR_RX_CTRL, 32'(2 * pairs));
      join
      check_burst("rx_burst", pairs, 12'd0, 1'b0);
      pairs = 2 + int'($urandom % 32'd4);
      fork
         collect_rx(-1);
         send_ctrl(`SR_RX_CTRL, 32'(2 * pairs));
      join
      check_burst("rx_second_burst", pairs, 12'd1, 1'b0);

      // RX overflow from a stall in mid-burst
      pairs = 8;
      fork
         collect_rx(2);
         send_ctrl(`SR_RX_CTRL, 32'd16);
      join
      check_burst("rx_overflow", pairs, 12'd2, 1'b1);
      send_ctrl(`SR_READBACK, {29'd0, `RB_STATUS});
      check_value(resp_rb[13], "rx_overflow_flag", 64'd1, 64'(resp_rb[13]));
      check_value(resp_rb[11:0] == 12'd3, "rx_seqnum", 64'd3, 64'(resp_rb[11:0]));

      $display("checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, u_dut.u_checker.fail_count);
      if (errors == 0 && u_dut.u_checker.fail_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

//--- verilog.f
+incdir+hdl
hdl/radio_pkg.sv
hdl/radio_ctrl_proc.sv
hdl/timekeeper.sv
hdl/radio_settings.sv
hdl/tx_sample_path.sv
hdl/rx_framer.sv
hdl/radio_core.sv
verif/radio_checker.sv
verif/radio_core_tb.sv

//--- run_sim.sh
#!/bin/bash
# Builds the radio core testbench with Verilator and runs it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module radio_core_tb &&
./obj_dir/Vradio_core_tb | tee /dev/stderr | grep -q "^PASS: all tests$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
